/* Bender.yml */
package:
  name: fsa_header

sources:
  - rtl/fsa_pkg.sv
  - rtl/fsa_col_if.sv
  - rtl/fsa_column_store.sv
  - rtl/fsa_scan_ctrl.sv
  - rtl/fsa_edge_locate.sv
  - rtl/fsa_detect_header.sv
  - rtl/fsa_header_top.sv
  - target: test
    files:
      - sim/tb_fsa_header.sv

/* list.f */
rtl/fsa_pkg.sv
rtl/fsa_col_if.sv
rtl/fsa_column_store.sv
rtl/fsa_scan_ctrl.sv
rtl/fsa_edge_locate.sv
rtl/fsa_detect_header.sv
rtl/fsa_header_top.sv
sim/tb_fsa_header.sv

/* rtl/fsa_col_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fsa_col_if;
	import fsa_pkg::*;

	// column controls, stage p3
	logic en;
	logic [C_IMG_WW-1:0] x;
	logic wfirst;
	logic wlast;
	pass_t pass;

	// record of column x, valid while en is high
	col_t col;

	modport ctrl (
		output en, x, wfirst, wlast, pass
	);

	modport store (
		output col
	);

	modport sink (
		input en, x, wfirst, wlast, pass, col
	);

endinterface

`default_nettype wire

/* rtl/fsa_column_store.sv */
`timescale 1ns/1ps
`default_nettype none

module fsa_column_store (
	input  logic clk,
	input  logic wr_en,
	input  logic [fsa_pkg::C_ADDR_W-1:0] wr_addr,
	input  fsa_pkg::col_t wr_col,
	input  logic rd_en,
	input  logic [fsa_pkg::C_ADDR_W-1:0] rd_addr,
	fsa_col_if.store colbus
);
	import fsa_pkg::*;

	col_t mem [C_MAX_COLS];

	// loader side
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_col;
		end
	end

	// scan side, entry shows up one cycle after rd_en
	always_ff @(posedge clk) begin
		if (rd_en) begin
			colbus.col <= mem[rd_addr];
		end
	end

	// loader and scan must never touch the same column together
	a_no_rw_collision: assert property (
		@(posedge clk) !(wr_en && rd_en && (wr_addr == rd_addr))
	) else $error("column store write and read hit address %0d", wr_addr);

endmodule

`default_nettype wire

/* rtl/fsa_detect_header.sv */
`timescale 1ns/1ps
`default_nettype none

module fsa_detect_header (
	input  logic clk,
	input  logic resetn,
	fsa_col_if.sink colbus,
	input  logic [fsa_pkg::C_IMG_WW-1:0] lft_edge,
	input  logic [fsa_pkg::C_IMG_WW-1:0] rt_edge,
	output logic lft_header_valid,
	output logic [fsa_pkg::C_IMG_WW-1:0] lft_header_x,
	output logic [fsa_pkg::C_IMG_HW-1:0] lft_header_y,
	output logic rt_header_valid,
	output logic [fsa_pkg::C_IMG_WW-1:0] rt_header_x,
	output logic [fsa_pkg::C_IMG_HW-1:0] rt_header_y
);
	import fsa_pkg::*;

	logic [C_IMG_HW-1:0] h_p3;
	logic [C_IMG_HW:0] ysum_p3;
	logic en_p4;
	pass_t pass_p4;
	logic [C_IMG_WW-1:0] x_p4;
	logic val_p4;
	logic [C_IMG_HW-1:0] h_p4;
	logic [C_IMG_HW-1:0] yc_p4;
	logic [C_IMG_HW-1:0] lft_lo;
	logic [C_IMG_HW-1:0] lft_hi;
	logic [C_IMG_HW-1:0] rt_lo;
	logic [C_IMG_HW-1:0] rt_hi;
	logic [C_FIBER_THICKNESS_LEN-1:0] lft_win;
	logic [C_FIBER_THICKNESS_LEN-1:0] lft_win_nx;
	logic [C_FIBER_THICKNESS_LEN-1:0] rt_win;
	logic [C_FIBER_THICKNESS_LEN-1:0] rt_win_nx;
	logic lft_take;
	logic rt_take;
	logic rt_armed;
	logic lft_y_open;
	logic rt_y_open;
	logic hpass_p4;
	logic xpass_p4;
	logic ypass_p4;

	assign h_p3 = colbus.col.bot - colbus.col.top;
	assign ysum_p3 = {1'b0, colbus.col.top} + {1'b0, colbus.col.bot};

	// stage p4 copy of the column
	always_ff @(posedge clk) begin
		if (!resetn) begin
			en_p4 <= 1'b0;
			pass_p4 <= PASS_IDLE;
		end else begin
			en_p4 <= colbus.en;
			pass_p4 <= colbus.pass;
		end
	end

	always_ff @(posedge clk) begin
		x_p4 <= colbus.x;
		val_p4 <= colbus.col.val;
		h_p4 <= h_p3;
		yc_p4 <= ysum_p3[C_IMG_HW:1];
	end

	assign hpass_p4 = en_p4 && (pass_p4 == PASS_HEIGHT);
	assign xpass_p4 = en_p4 && (pass_p4 == PASS_X);
	assign ypass_p4 = en_p4 && (pass_p4 == PASS_Y);

	// reference heights from first and last column, lower bound saturates at zero
	always_ff @(posedge clk) begin
		if (!resetn) begin
			lft_lo <= '0;
			lft_hi <= '0;
			rt_lo <= '0;
			rt_hi <= '0;
		end else if (colbus.en && (colbus.pass == PASS_HEIGHT)) begin
			if (colbus.wfirst) begin
				lft_hi <= h_p3 + C_IMG_HW'(C_FIBER_HEIGHT_TOL);
				lft_lo <= (h_p3 > C_IMG_HW'(C_FIBER_HEIGHT_TOL)) ?
					h_p3 - C_IMG_HW'(C_FIBER_HEIGHT_TOL) : '0;
			end
			if (colbus.wlast) begin
				rt_hi <= h_p3 + C_IMG_HW'(C_FIBER_HEIGHT_TOL);
				rt_lo <= (h_p3 > C_IMG_HW'(C_FIBER_HEIGHT_TOL)) ?
					h_p3 - C_IMG_HW'(C_FIBER_HEIGHT_TOL) : '0;
			end
		end
	end

	// window ends at the current column, absent columns never count
	assign lft_win_nx = {lft_win[C_FIBER_THICKNESS_LEN-2:0],
		val_p4 && (h_p4 >= lft_lo) && (h_p4 <= lft_hi)};
	assign rt_win_nx = {rt_win[C_FIBER_THICKNESS_LEN-2:0],
		val_p4 && (h_p4 >= rt_lo) && (h_p4 <= rt_hi)};

	assign lft_take = !lft_header_valid && (&lft_win_nx) && (x_p4 <= lft_edge);
	assign rt_take = rt_armed && !rt_header_valid && (&rt_win_nx);

	always_ff @(posedge clk) begin
		if (!resetn || hpass_p4) begin
			lft_win <= '0;
			lft_header_valid <= 1'b0;
			lft_header_x <= '0;
		end else if (xpass_p4) begin
			lft_win <= lft_win_nx;
			if (lft_take) begin
				lft_header_valid <= 1'b1;
				lft_header_x <= x_p4 - C_IMG_WW'(C_FIBER_THICKNESS_LEN_HALF + 1);
			end
		end
	end

	// right search starts on the column after rt_edge
	always_ff @(posedge clk) begin
		if (!resetn || hpass_p4) begin
			rt_win <= '0;
			rt_armed <= 1'b0;
			rt_header_valid <= 1'b0;
			rt_header_x <= '0;
		end else if (xpass_p4) begin
			rt_win <= rt_win_nx;
			if (x_p4 == rt_edge) begin
				rt_armed <= 1'b1;
			end
			if (rt_take) begin
				rt_header_valid <= 1'b1;
				rt_header_x <= x_p4 - C_IMG_WW'(C_FIBER_THICKNESS_LEN_HALF + 1);
			end
		end
	end

	// centre row, followed up to the header column, stays zero without a header
	always_ff @(posedge clk) begin
		if (!resetn || xpass_p4) begin
			lft_y_open <= 1'b1;
			lft_header_y <= '0;
		end else if (ypass_p4 && lft_header_valid && lft_y_open) begin
			lft_header_y <= yc_p4;
			if (x_p4 == lft_header_x) begin
				lft_y_open <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn || xpass_p4) begin
			rt_y_open <= 1'b1;
			rt_header_y <= '0;
		end else if (ypass_p4 && rt_header_valid && rt_y_open) begin
			rt_header_y <= yc_p4;
			if (x_p4 == rt_header_x) begin
				rt_y_open <= 1'b0;
			end
		end
	end

	// controller must tag every issued column with a real pass
	a_pass_on_en: assert property (
		@(posedge clk) disable iff (!resetn) colbus.en |-> (colbus.pass != PASS_IDLE)
	) else $error("column %0d issued without a scan pass", colbus.x);

endmodule

`default_nettype wire

/* rtl/fsa_edge_locate.sv */
`timescale 1ns/1ps
`default_nettype none

module fsa_edge_locate (
	input  logic clk,
	input  logic resetn,
	fsa_col_if.sink colbus,
	output logic [fsa_pkg::C_IMG_WW-1:0] lft_edge,
	output logic [fsa_pkg::C_IMG_WW-1:0] rt_edge
);
	import fsa_pkg::*;

	// before left run, inside it, in the gap, right start found
	typedef enum logic [1:0] {
		ST_SEEK,
		ST_RUN,
		ST_GAP,
		ST_DONE
	} edge_st_t;

	edge_st_t st;
	edge_st_t st_cur;
	edge_st_t st_next;
	logic hpass;
	logic lft_hit;
	logic rt_hit;

	assign hpass = colbus.en && (colbus.pass == PASS_HEIGHT);

	// first column of the pass restarts the search
	assign st_cur = colbus.wfirst ? ST_SEEK : st;

	always_comb begin
		st_next = st_cur;
		lft_hit = 1'b0;
		rt_hit = 1'b0;
		case (st_cur)
			ST_SEEK: begin
				if (colbus.col.val) begin
					st_next = ST_RUN;
					lft_hit = 1'b1;
				end
			end
			ST_RUN: begin
				if (colbus.col.val) begin
					lft_hit = 1'b1;
				end else begin
					st_next = ST_GAP;
				end
			end
			ST_GAP: begin
				if (colbus.col.val) begin
					st_next = ST_DONE;
					rt_hit = 1'b1;
				end
			end
			default: st_next = ST_DONE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			st <= ST_SEEK;
			lft_edge <= '0;
			rt_edge <= '0;
		end else if (hpass) begin
			st <= st_next;
			if (lft_hit) begin
				lft_edge <= colbus.x;
			end
			if (rt_hit) begin
				rt_edge <= colbus.x;
			end
			// no right fiber start, both edges fall back to the last column
			if (colbus.wlast && (st_next != ST_DONE)) begin
				lft_edge <= colbus.x;
				rt_edge <= colbus.x;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/fsa_header_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fsa_header_top (
	input  logic clk,
	input  logic resetn,
	input  logic wr_en,
	input  logic [fsa_pkg::C_ADDR_W-1:0] wr_addr,
	input  logic wr_val,
	input  logic [fsa_pkg::C_IMG_HW-1:0] wr_top,
	input  logic [fsa_pkg::C_IMG_HW-1:0] wr_bot,
	input  logic [fsa_pkg::C_IMG_WW-1:0] img_width,
	input  logic start,
	output logic busy,
	output logic done,
	output logic lft_header_valid,
	output logic [fsa_pkg::C_IMG_WW-1:0] lft_header_x,
	output logic [fsa_pkg::C_IMG_HW-1:0] lft_header_y,
	output logic rt_header_valid,
	output logic [fsa_pkg::C_IMG_WW-1:0] rt_header_x,
	output logic [fsa_pkg::C_IMG_HW-1:0] rt_header_y
);
	import fsa_pkg::*;

	col_t wr_col;
	logic rd_en;
	logic [C_ADDR_W-1:0] rd_addr;
	logic [C_IMG_WW-1:0] lft_edge;
	logic [C_IMG_WW-1:0] rt_edge;

	assign wr_col = '{val: wr_val, top: wr_top, bot: wr_bot};

	// column at stage p3
	fsa_col_if i_colbus ();

	fsa_column_store i_store (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_col  (wr_col),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.colbus  (i_colbus.store)
	);

	fsa_scan_ctrl i_scan_ctrl (
		.clk       (clk),
		.resetn    (resetn),
		.start     (start),
		.img_width (img_width),
		.rd_en     (rd_en),
		.rd_addr   (rd_addr),
		.busy      (busy),
		.done      (done),
		.colbus    (i_colbus.ctrl)
	);

	fsa_edge_locate i_edge_locate (
		.clk      (clk),
		.resetn   (resetn),
		.colbus   (i_colbus.sink),
		.lft_edge (lft_edge),
		.rt_edge  (rt_edge)
	);

	fsa_detect_header i_detect_header (
		.clk              (clk),
		.resetn           (resetn),
		.colbus           (i_colbus.sink),
		.lft_edge         (lft_edge),
		.rt_edge          (rt_edge),
		.lft_header_valid (lft_header_valid),
		.lft_header_x     (lft_header_x),
		.lft_header_y     (lft_header_y),
		.rt_header_valid  (rt_header_valid),
		.rt_header_x      (rt_header_x),
		.rt_header_y      (rt_header_y)
	);

endmodule

`default_nettype wire

/* rtl/fsa_pkg.sv */
`default_nettype none

package fsa_pkg;

	// image geometry
	localparam int C_IMG_WW = 12;
	localparam int C_IMG_HW = 12;

	// column store, image width at run time must not exceed the depth
	localparam int C_MAX_COLS = 256;
	localparam int C_ADDR_W = 8;

	// header search
	localparam int C_FIBER_HEIGHT_TOL = 2;
	localparam int C_FIBER_THICKNESS_LEN_HALF = 5;
	localparam int C_FIBER_THICKNESS_LEN = 2 * C_FIBER_THICKNESS_LEN_HALF + 1;

	// scan passes in issue order
	typedef enum logic [1:0] {
		PASS_IDLE,
		PASS_HEIGHT,
		PASS_X,
		PASS_Y
	} pass_t;

	// one column of the fiber silhouette
	typedef struct packed {
		logic val;
		logic [C_IMG_HW-1:0] top;
		logic [C_IMG_HW-1:0] bot;
	} col_t;

endpackage

`default_nettype wire

/* rtl/fsa_scan_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fsa_scan_ctrl (
	input  logic clk,
	input  logic resetn,
	input  logic start,
	input  logic [fsa_pkg::C_IMG_WW-1:0] img_width,
	output logic rd_en,
	output logic [fsa_pkg::C_ADDR_W-1:0] rd_addr,
	output logic busy,
	output logic done,
	fsa_col_if.ctrl colbus
);
	import fsa_pkg::*;

	pass_t pass;
	logic [C_IMG_WW-1:0] cnt;
	logic [C_IMG_WW-1:0] width_q;
	logic [C_IMG_WW-1:0] last_idx;
	logic accept;
	logic last_y_p2;
	// last y column travelling through p3, p4 and the detector update
	logic [2:0] tail;

	assign accept = start && !busy;
	assign last_idx = width_q - 1'b1;

	// stage p2 read request
	assign rd_en = (pass != PASS_IDLE);
	assign rd_addr = cnt[C_ADDR_W-1:0];
	assign last_y_p2 = rd_en && (pass == PASS_Y) && (cnt == last_idx);

	always_ff @(posedge clk) begin
		if (accept) begin
			width_q <= img_width;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			pass <= PASS_IDLE;
			cnt <= '0;
			busy <= 1'b0;
			done <= 1'b0;
			tail <= '0;
		end else begin
			tail <= {tail[1:0], last_y_p2};
			done <= tail[2];
			if (accept) begin
				busy <= 1'b1;
				pass <= PASS_HEIGHT;
				cnt <= '0;
			end else if (done) begin
				// busy covers the done cycle
				busy <= 1'b0;
			end
			if (rd_en) begin
				if (cnt == last_idx) begin
					cnt <= '0;
					case (pass)
						PASS_HEIGHT: pass <= PASS_X;
						PASS_X: pass <= PASS_Y;
						default: pass <= PASS_IDLE;
					endcase
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	// align controls with the store output
	always_ff @(posedge clk) begin
		if (!resetn) begin
			colbus.en <= 1'b0;
			colbus.pass <= PASS_IDLE;
		end else begin
			colbus.en <= rd_en;
			colbus.pass <= pass;
		end
	end

	always_ff @(posedge clk) begin
		colbus.x <= cnt;
		colbus.wfirst <= (cnt == '0);
		colbus.wlast <= (cnt == last_idx);
	end

	a_cnt_in_range: assert property (
		@(posedge clk) disable iff (!resetn) busy |-> (cnt < width_q)
	) else $error("column counter %0d outside image width %0d", cnt, width_q);

endmodule

`default_nettype wire

/* sim/tb_fsa_header.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fsa_header;
	import fsa_pkg::*;

	localparam int C_CLK_HALF = 20;
	localparam int C_RND_MAX_W = 200;
	// per scan 3*width+20 cycles, doubled to cover loading
	localparam int C_WATCH_CYCLES = 2 * ((3 * 64 + 20) * 3 + (3 * C_RND_MAX_W + 20) * 20
		+ (3 * 96 + 20) * 2) + 500;

	logic clk;
	logic resetn;
	logic wr_en;
	logic [C_ADDR_W-1:0] wr_addr;
	logic wr_val;
	logic [C_IMG_HW-1:0] wr_top;
	logic [C_IMG_HW-1:0] wr_bot;
	logic [C_IMG_WW-1:0] img_width;
	logic start;
	logic busy;
	logic done;
	logic lft_header_valid;
	logic [C_IMG_WW-1:0] lft_header_x;
	logic [C_IMG_HW-1:0] lft_header_y;
	logic rt_header_valid;
	logic [C_IMG_WW-1:0] rt_header_x;
	logic [C_IMG_HW-1:0] rt_header_y;

	// image under test and model results
	col_t img [C_MAX_COLS];
	int width;
	int m_le;
	int m_re;
	logic m_lv;
	logic [C_IMG_WW-1:0] m_lx;
	logic [C_IMG_HW-1:0] m_ly;
	logic m_rv;
	logic [C_IMG_WW-1:0] m_rx;
	logic [C_IMG_HW-1:0] m_ry;

	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int unsigned lcg_state = 29;
	logic stall = 1'b0;

	fsa_header_top i_fsa_header_top (
		.clk              (clk),
		.resetn           (resetn),
		.wr_en            (wr_en),
		.wr_addr          (wr_addr),
		.wr_val           (wr_val),
		.wr_top           (wr_top),
		.wr_bot           (wr_bot),
		.img_width        (img_width),
		.start            (start),
		.busy             (busy),
		.done             (done),
		.lft_header_valid (lft_header_valid),
		.lft_header_x     (lft_header_x),
		.lft_header_y     (lft_header_y),
		.rt_header_valid  (rt_header_valid),
		.rt_header_x      (rt_header_x),
		.rt_header_y      (rt_header_y)
	);

	initial begin
		clk = 1'b0;
		forever #(C_CLK_HALF) clk = ~clk;
	end

	function automatic int rand_below(input int n);
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return int'((lcg_state >> 8) % n);
	endfunction

	task automatic check_flag(input string what, input logic exp, input logic got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_col(input int idx, input col_t exp, input col_t got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t ns: stored column %0d is %b/%0d/%0d, expected %b/%0d/%0d",
				$time, idx, got.val, got.top, got.bot, exp.val, exp.top, exp.bot);
		end
	endtask

	task automatic check_header(input string what, input logic exp_v,
		input logic [C_IMG_WW-1:0] exp_x, input logic [C_IMG_HW-1:0] exp_y,
		input logic got_v, input logic [C_IMG_WW-1:0] got_x, input logic [C_IMG_HW-1:0] got_y);
		checks++;
		if ({got_v, got_x, got_y} !== {exp_v, exp_x, exp_y}) begin
			errors++;
			$display("ERROR at %0t ns: %s is v=%b x=%0d y=%0d, expected v=%b x=%0d y=%0d",
				$time, what, got_v, got_x, got_y, exp_v, exp_x, exp_y);
		end
	endtask

	function automatic logic [C_IMG_HW-1:0] col_height(input col_t c);
		return c.bot - c.top;
	endfunction

	function automatic logic [C_IMG_HW-1:0] band_lo(input logic [C_IMG_HW-1:0] h);
		return (h > C_FIBER_HEIGHT_TOL) ? h - C_IMG_HW'(C_FIBER_HEIGHT_TOL) : '0;
	endfunction

	// all columns from x-10 to x present and inside the band
	function automatic logic window_full(input int x, input logic [C_IMG_HW-1:0] lo,
		input logic [C_IMG_HW-1:0] hi);
		logic [C_IMG_HW-1:0] h;
		for (int k = x - C_FIBER_THICKNESS_LEN + 1; k <= x; k++) begin
			h = col_height(img[k]);
			if (!img[k].val || h < lo || h > hi) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	task automatic model_scan();
		int st;
		int x0;
		logic [C_IMG_HW-1:0] llo;
		logic [C_IMG_HW-1:0] lhi;
		logic [C_IMG_HW-1:0] rlo;
		logic [C_IMG_HW-1:0] rhi;
		logic [C_IMG_HW:0] ysum;
		// edges: end of first run, start after the first gap
		st = 0;
		m_le = 0;
		m_re = 0;
		for (int x = 0; x < width; x++) begin
			case (st)
				0: if (img[x].val) begin
					st = 1;
					m_le = x;
				end
				1: if (img[x].val) m_le = x; else st = 2;
				2: if (img[x].val) begin
					st = 3;
					m_re = x;
				end
				default: ;
			endcase
		end
		if (st != 3) begin
			m_le = width - 1;
			m_re = width - 1;
		end
		llo = band_lo(col_height(img[0]));
		lhi = col_height(img[0]) + C_IMG_HW'(C_FIBER_HEIGHT_TOL);
		rlo = band_lo(col_height(img[width-1]));
		rhi = col_height(img[width-1]) + C_IMG_HW'(C_FIBER_HEIGHT_TOL);
		{m_lv, m_lx, m_ly, m_rv, m_rx, m_ry} = '0;
		for (int x = C_FIBER_THICKNESS_LEN - 1; x < width && x <= m_le; x++) begin
			if (!m_lv && window_full(x, llo, lhi)) begin
				m_lv = 1'b1;
				m_lx = C_IMG_WW'(x - C_FIBER_THICKNESS_LEN_HALF - 1);
			end
		end
		x0 = (m_re + 1 > C_FIBER_THICKNESS_LEN - 1) ? m_re + 1 : C_FIBER_THICKNESS_LEN - 1;
		for (int x = x0; x < width; x++) begin
			if (!m_rv && window_full(x, rlo, rhi)) begin
				m_rv = 1'b1;
				m_rx = C_IMG_WW'(x - C_FIBER_THICKNESS_LEN_HALF - 1);
			end
		end
		if (m_lv) begin
			ysum = {1'b0, img[m_lx].top} + {1'b0, img[m_lx].bot};
			m_ly = ysum[C_IMG_HW:1];
		end
		if (m_rv) begin
			ysum = {1'b0, img[m_rx].top} + {1'b0, img[m_rx].bot};
			m_ry = ysum[C_IMG_HW:1];
		end
	endtask

	// mode 0 uniform, 1 left height alternating out of band, 2 random noise
	task automatic build_image(input int w, input int lend, input int gap, input int lh,
		input int rh, input int mode);
		int h;
		int cy;
		int n;
		logic v;
		width = w;
		for (int i = 0; i < C_MAX_COLS; i++) begin
			img[i] = '0;
		end
		for (int i = 0; i < w; i++) begin
			v = 1'b1;
			cy = 100;
			if (i <= lend) begin
				h = (mode == 1 && (i % 2 == 1)) ? lh + 10 : lh;
			end else if (i <= lend + gap) begin
				v = 1'b0;
				h = 0;
			end else begin
				h = rh;
			end
			if (mode == 2 && v) begin
				n = rand_below(16);
				if (n >= 10 && n < 12) h = h + 1;
				else if (n >= 12 && n < 14) h = h - 1;
				else if (n == 14) h = h + 3;
				else if (n == 15) h = h - 4;
				cy = 200 + rand_below(50);
				if (rand_below(40) == 0) v = 1'b0;
			end
			if (v) begin
				img[i] = '{val: 1'b1, top: C_IMG_HW'(cy - h / 2), bot: C_IMG_HW'(cy - h / 2 + h)};
			end
		end
	endtask

	task automatic load_image();
		for (int i = 0; i < width; i++) begin
			@(negedge clk);
			wr_en = 1'b1;
			wr_addr = C_ADDR_W'(i);
			wr_val = img[i].val;
			wr_top = img[i].top;
			wr_bot = img[i].bot;
		end
		@(negedge clk);
		wr_en = 1'b0;
		for (int i = 0; i < width; i++) begin
			check_col(i, img[i], i_fsa_header_top.i_store.mem[i]);
		end
	endtask

	task automatic wait_done(input int w);
		int n;
		n = 0;
		while (!done && n < 3 * w + 50) begin
			@(negedge clk);
			n++;
		end
		if (!done) begin
			// watchdog reports the stall and ends the run
			stall = 1'b1;
			forever @(posedge clk);
		end
	endtask

	task automatic run_scan(input logic stray_start);
		@(negedge clk);
		img_width = C_IMG_WW'(width);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		check_flag("busy after start", 1'b1, busy);
		if (stray_start) begin
			repeat (5) @(negedge clk);
			img_width = C_IMG_WW'(10);
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
			img_width = C_IMG_WW'(width);
		end
		wait_done(width);
		check_flag("busy in done cycle", 1'b1, busy);
		model_scan();
		check_header("left header", m_lv, m_lx, m_ly,
			lft_header_valid, lft_header_x, lft_header_y);
		check_header("right header", m_rv, m_rx, m_ry,
			rt_header_valid, rt_header_x, rt_header_y);
		@(negedge clk);
		check_flag("done after one cycle", 1'b0, done);
		check_flag("busy after done", 1'b0, busy);
	endtask

	task automatic report_test(input string name, input int e0);
		tests_run++;
		if (errors == e0) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d mismatches", name, errors - e0);
		end
	endtask

	task automatic test_reset();
		int e0;
		e0 = errors;
		check_flag("busy", 1'b0, busy);
		check_flag("done", 1'b0, done);
		check_header("left header", 1'b0, '0, '0, lft_header_valid, lft_header_x, lft_header_y);
		check_header("right header", 1'b0, '0, '0, rt_header_valid, rt_header_x, rt_header_y);
		report_test("reset state", e0);
	endtask

	task automatic test_clean();
		int e0;
		e0 = errors;
		build_image(64, 29, 6, 20, 16, 0);
		load_image();
		run_scan(1'b0);
		// left window full at column 10, right fiber starts at 36
		check_header("left header, clean image", 1'b1, 12'd4, 12'd100,
			lft_header_valid, lft_header_x, lft_header_y);
		check_header("right header, clean image", 1'b1, 12'd40, 12'd100,
			rt_header_valid, rt_header_x, rt_header_y);
		report_test("clean image", e0);
	endtask

	task automatic test_left_noisy();
		int e0;
		e0 = errors;
		build_image(64, 29, 6, 20, 16, 1);
		load_image();
		run_scan(1'b0);
		check_flag("left header valid, noisy fiber", 1'b0, lft_header_valid);
		report_test("noisy left fiber", e0);
	endtask

	task automatic test_random();
		int e0;
		int w;
		int lend;
		int gap;
		int lh;
		int rh;
		e0 = errors;
		for (int k = 0; k < 20; k++) begin
			w = 24 + rand_below(C_RND_MAX_W - 23);
			lend = 3 + rand_below(w / 2);
			gap = rand_below(6);
			lh = 8 + rand_below(40);
			rh = 8 + rand_below(40);
			build_image(w, lend, gap, lh, rh, 2);
			load_image();
			run_scan(1'b0);
		end
		report_test("random images", e0);
	endtask

	task automatic test_back_to_back();
		int e0;
		int extra_done;
		logic busy_seen;
		logic a_lv;
		logic [C_IMG_WW-1:0] a_lx;
		logic [C_IMG_HW-1:0] a_ly;
		e0 = errors;
		build_image(64, 29, 6, 20, 16, 0);
		load_image();
		run_scan(1'b0);
		a_lv = m_lv;
		a_lx = m_lx;
		a_ly = m_ly;
		build_image(96, 40, 4, 30, 22, 2);
		load_image();
		// first result still held until the next start
		check_header("left header held", a_lv, a_lx, a_ly,
			lft_header_valid, lft_header_x, lft_header_y);
		run_scan(1'b1);
		extra_done = 0;
		busy_seen = 1'b0;
		repeat (3 * 96 + 20) begin
			@(negedge clk);
			if (done) extra_done++;
			if (busy) busy_seen = 1'b1;
		end
		check_flag("single done pulse", 1'b1, extra_done == 0);
		check_flag("busy after second scan", 1'b0, busy_seen);
		report_test("back to back scans", e0);
	endtask

	initial begin : watchdog
		fork
			#(C_WATCH_CYCLES * 2 * C_CLK_HALF);
			wait (stall);
		join_any
		if (stall) begin
			$display("scan stalled, no done pulse within the expected time");
		end else begin
			$display("watchdog time limit reached, run stopped");
		end
		$display("Errors found");
		$finish;
	end

	initial begin
		resetn = 1'b0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_val = 1'b0;
		wr_top = '0;
		wr_bot = '0;
		img_width = '0;
		start = 1'b0;
		repeat (10) @(negedge clk);
		resetn = 1'b1;
		@(negedge clk);
		test_reset();
		test_clean();
		test_left_noisy();
		test_random();
		test_back_to_back();
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
